//--- logic/xbar_defines.svh
// ======================================
// Crossbar size and address map constants
// Target t owns the window starting at
// t * XBAR_TGT_SIZE; all above is unmapped
// ======================================
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// Port counts
`define XBAR_NUM_INIT 2
`define XBAR_NUM_TGT 2

// Bus widths
`define XBAR_ADDR_W 16
`define XBAR_DATA_W 32

// Outstanding requests per initiator
`define XBAR_MAX_TRANS 4

// Size of one target window
`define XBAR_TGT_SIZE 16'h1000

`endif

//--- logic/xbar_map_pkg.sv
// ======================================
// Index, ID and payload types
// Address map is fixed at elaboration
// Rule end address is exclusive
// ======================================
`default_nettype none

`include "xbar_defines.svh"

package xbar_map_pkg;

  // Initiator index, also the ID seen by targets
  typedef logic [$clog2(`XBAR_NUM_INIT)-1:0] init_idx_t;
  typedef init_idx_t id_t;

  // Demux select, one slot above the targets for decode error
  typedef logic [$clog2(`XBAR_NUM_TGT + 1)-1:0] tgt_sel_t;

  typedef logic [`XBAR_ADDR_W-1:0] addr_t;
  typedef logic [`XBAR_DATA_W-1:0] data_t;

  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } tgt_rule_t;

  typedef tgt_rule_t [`XBAR_NUM_TGT-1:0] addr_map_t;

  // Contiguous windows of equal size, target 0 at address zero
  function automatic addr_map_t gen_addr_map();
    addr_map_t map;
    for (int t = 0; t < `XBAR_NUM_TGT; t++) begin
      map[t].start_addr = addr_t'(t * `XBAR_TGT_SIZE);
      map[t].end_addr   = addr_t'((t + 1) * `XBAR_TGT_SIZE);
    end
    return map;
  endfunction

  localparam addr_map_t ADDR_MAP = gen_addr_map();

endpackage

`default_nettype wire

//--- logic/xbar_bus_pkg.sv
// ======================================
// Bus opcodes, status and FSM states
// Encodings are one bit each
// ======================================
`default_nettype none

package xbar_bus_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } xbar_op_e;

  typedef enum logic {
    RSP_OKAY   = 1'b0,
    RSP_DECERR = 1'b1
  } xbar_status_e;

  // Target arbiter states
  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_HOLD = 1'b1
  } arb_state_e;

  // Decode error target states
  typedef enum logic {
    DE_IDLE = 1'b0,
    DE_RESP = 1'b1
  } decerr_state_e;

endpackage

`default_nettype wire

//--- logic/xbar_trans_counter.sv
// ======================================
// Outstanding transaction counter
// Saturation is prevented by the demux
// stall, never by this block itself
// ======================================
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defines.svh"

module xbar_trans_counter (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_fire_i,
  input  logic                   rsp_fire_i,
  input  xbar_map_pkg::tgt_sel_t req_sel_i,
  output logic                   busy_o,
  output logic                   full_o,
  output xbar_map_pkg::tgt_sel_t locked_sel_o
);

  localparam int unsigned CNT_W = $clog2(`XBAR_MAX_TRANS + 1);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q      <= '0;
      locked_sel_o <= '0;
    end else begin
      // Simultaneous request and response leave the count as is
      if (req_fire_i && !rsp_fire_i) begin
        count_q <= count_q + 1'b1;
      end else if (rsp_fire_i && !req_fire_i) begin
        count_q <= count_q - 1'b1;
      end
      // Target of the newest request in flight
      if (req_fire_i) begin
        locked_sel_o <= req_sel_i;
      end
    end
  end

  assign busy_o = (count_q != '0);
  assign full_o = (count_q == CNT_W'(`XBAR_MAX_TRANS));

  // A response needs a request still in flight
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_fire_i |-> busy_o);

  // Stall logic must block requests at the limit
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_fire_i && !rsp_fire_i) |-> (count_q < CNT_W'(`XBAR_MAX_TRANS)));

endmodule

`default_nettype wire

//--- logic/xbar_decerr_target.sv
// ======================================
// Decode error target
// One request at a time; status and zero
// data are added by the demux
// ======================================
`timescale 1ns/10ps
`default_nettype none

module xbar_decerr_target (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic req_valid_i,
  output logic req_ready_o,
  output logic rsp_valid_o,
  input  logic rsp_ready_i
);

  xbar_bus_pkg::decerr_state_e state_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= xbar_bus_pkg::DE_IDLE;
    end else begin
      case (state_q)
        // Take the request in the cycle it shows up
        xbar_bus_pkg::DE_IDLE: begin
          if (req_valid_i) begin
            state_q <= xbar_bus_pkg::DE_RESP;
          end
        end
        // Offer the answer until the initiator takes it
        xbar_bus_pkg::DE_RESP: begin
          if (rsp_ready_i) begin
            state_q <= xbar_bus_pkg::DE_IDLE;
          end
        end
        default: state_q <= xbar_bus_pkg::DE_IDLE;
      endcase
    end
  end

  assign req_ready_o = (state_q == xbar_bus_pkg::DE_IDLE);
  assign rsp_valid_o = (state_q == xbar_bus_pkg::DE_RESP);

  // Response stays offered until the handshake
  a_rsp_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rsp_valid_o && !rsp_ready_i) |=> rsp_valid_o);

endmodule

`default_nettype wire

//--- logic/xbar_init_demux.sv
// ======================================
// Per-initiator request demux
// Stalls on a full counter or a change of
// target while requests are in flight
// ======================================
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defines.svh"

module xbar_init_demux (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  xbar_map_pkg::addr_t                         req_addr_i,
  output logic                                        rsp_valid_o,
  input  logic                                        rsp_ready_i,
  output xbar_map_pkg::data_t                         rsp_rdata_o,
  output xbar_bus_pkg::xbar_status_e                  rsp_status_o,
  output logic [`XBAR_NUM_TGT-1:0]                    tgt_req_valid_o,
  input  logic [`XBAR_NUM_TGT-1:0]                    tgt_req_ready_i,
  input  logic [`XBAR_NUM_TGT-1:0]                    tgt_rsp_valid_i,
  output logic [`XBAR_NUM_TGT-1:0]                    tgt_rsp_ready_o,
  input  xbar_map_pkg::data_t [`XBAR_NUM_TGT-1:0]     tgt_rsp_rdata_i
);

  // Decode error slot sits just above the real targets
  localparam xbar_map_pkg::tgt_sel_t DE_SEL = xbar_map_pkg::tgt_sel_t'(`XBAR_NUM_TGT);

  xbar_map_pkg::tgt_sel_t dec_sel;
  xbar_map_pkg::tgt_sel_t locked_sel;
  logic                   busy;
  logic                   full;
  logic                   stall;
  logic                   de_req_valid;
  logic                   de_req_ready;
  logic                   de_rsp_valid;
  logic                   de_rsp_ready;

  // Address decode, falls back to the error slot
  always_comb begin
    dec_sel = DE_SEL;
    for (int t = 0; t < `XBAR_NUM_TGT; t++) begin
      if (req_addr_i >= xbar_map_pkg::ADDR_MAP[t].start_addr &&
          req_addr_i <  xbar_map_pkg::ADDR_MAP[t].end_addr) begin
        dec_sel = xbar_map_pkg::tgt_sel_t'(t);
      end
    end
  end

  // Keeps responses in issue order
  assign stall = full || (busy && (dec_sel != locked_sel));

  // Request steering
  always_comb begin
    tgt_req_valid_o = '0;
    de_req_valid    = 1'b0;
    req_ready_o     = 1'b0;
    if (dec_sel == DE_SEL) begin
      de_req_valid = req_valid_i && !stall;
      req_ready_o  = de_req_ready && !stall;
    end
    for (int t = 0; t < `XBAR_NUM_TGT; t++) begin
      if (dec_sel == xbar_map_pkg::tgt_sel_t'(t)) begin
        tgt_req_valid_o[t] = req_valid_i && !stall;
        req_ready_o        = tgt_req_ready_i[t] && !stall;
      end
    end
  end

  // Response selection from the locked target only
  always_comb begin
    rsp_valid_o     = 1'b0;
    rsp_rdata_o     = '0;
    rsp_status_o    = xbar_bus_pkg::RSP_OKAY;
    tgt_rsp_ready_o = '0;
    de_rsp_ready    = 1'b0;
    if (locked_sel == DE_SEL) begin
      rsp_valid_o  = de_rsp_valid;
      rsp_status_o = xbar_bus_pkg::RSP_DECERR;
      de_rsp_ready = rsp_ready_i;
    end
    for (int t = 0; t < `XBAR_NUM_TGT; t++) begin
      if (locked_sel == xbar_map_pkg::tgt_sel_t'(t)) begin
        rsp_valid_o        = tgt_rsp_valid_i[t];
        rsp_rdata_o        = tgt_rsp_rdata_i[t];
        tgt_rsp_ready_o[t] = rsp_ready_i;
      end
    end
  end

  xbar_trans_counter i_trans_counter (
    .clk_i        ( clk_i                      ),
    .arst_n_i     ( arst_n_i                   ),
    .req_fire_i   ( req_valid_i && req_ready_o ),
    .rsp_fire_i   ( rsp_valid_o && rsp_ready_i ),
    .req_sel_i    ( dec_sel                    ),
    .busy_o       ( busy                       ),
    .full_o       ( full                       ),
    .locked_sel_o ( locked_sel                 )
  );

  xbar_decerr_target i_decerr_target (
    .clk_i       ( clk_i        ),
    .arst_n_i    ( arst_n_i     ),
    .req_valid_i ( de_req_valid ),
    .req_ready_o ( de_req_ready ),
    .rsp_valid_o ( de_rsp_valid ),
    .rsp_ready_i ( de_rsp_ready )
  );

endmodule

`default_nettype wire

//--- logic/xbar_tgt_arbiter.sv
// ======================================
// Per-target round-robin arbiter
// One idle cycle between grants
// ID carries the initiator index back
// ======================================
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defines.svh"

module xbar_tgt_arbiter (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic [`XBAR_NUM_INIT-1:0]                     req_valid_i,
  output logic [`XBAR_NUM_INIT-1:0]                     req_ready_o,
  input  xbar_map_pkg::addr_t [`XBAR_NUM_INIT-1:0]      req_addr_i,
  input  xbar_bus_pkg::xbar_op_e [`XBAR_NUM_INIT-1:0]   req_op_i,
  input  xbar_map_pkg::data_t [`XBAR_NUM_INIT-1:0]      req_wdata_i,
  output logic [`XBAR_NUM_INIT-1:0]                     rsp_valid_o,
  input  logic [`XBAR_NUM_INIT-1:0]                     rsp_ready_i,
  output logic                                          tgt_req_valid_o,
  input  logic                                          tgt_req_ready_i,
  output xbar_map_pkg::addr_t                           tgt_req_addr_o,
  output xbar_bus_pkg::xbar_op_e                        tgt_req_op_o,
  output xbar_map_pkg::data_t                           tgt_req_wdata_o,
  output xbar_map_pkg::id_t                             tgt_req_id_o,
  input  logic                                          tgt_rsp_valid_i,
  output logic                                          tgt_rsp_ready_o,
  input  xbar_map_pkg::id_t                             tgt_rsp_id_i
);

  xbar_bus_pkg::arb_state_e state_q;
  xbar_map_pkg::init_idx_t  grant_q;
  xbar_map_pkg::init_idx_t  next_grant;
  logic                     found;

  // Search starts one past the last grant
  always_comb begin
    xbar_map_pkg::init_idx_t idx;
    next_grant = grant_q;
    found      = 1'b0;
    for (int k = 1; k <= `XBAR_NUM_INIT; k++) begin
      idx = xbar_map_pkg::init_idx_t'((int'(grant_q) + k) % `XBAR_NUM_INIT);
      if (!found && req_valid_i[idx]) begin
        next_grant = idx;
        found      = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= xbar_bus_pkg::ARB_IDLE;
      grant_q <= '0;
    end else begin
      case (state_q)
        xbar_bus_pkg::ARB_IDLE: begin
          if (found) begin
            grant_q <= next_grant;
            state_q <= xbar_bus_pkg::ARB_HOLD;
          end
        end
        // Grant held until the target takes the request
        xbar_bus_pkg::ARB_HOLD: begin
          if (tgt_req_ready_i) begin
            state_q <= xbar_bus_pkg::ARB_IDLE;
          end
        end
        default: state_q <= xbar_bus_pkg::ARB_IDLE;
      endcase
    end
  end

  // Request side follows the held grant
  assign tgt_req_valid_o = (state_q == xbar_bus_pkg::ARB_HOLD);
  assign tgt_req_addr_o  = req_addr_i[grant_q];
  assign tgt_req_op_o    = req_op_i[grant_q];
  assign tgt_req_wdata_o = req_wdata_i[grant_q];
  assign tgt_req_id_o    = grant_q;

  always_comb begin
    req_ready_o = '0;
    rsp_valid_o = '0;
    req_ready_o[grant_q]      = tgt_req_valid_o && tgt_req_ready_i;
    // Response routed back by its ID
    rsp_valid_o[tgt_rsp_id_i] = tgt_rsp_valid_i;
  end

  assign tgt_rsp_ready_o = tgt_rsp_valid_i && rsp_ready_i[tgt_rsp_id_i];

  // Request and payload stay put while the target stalls
  a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (tgt_req_valid_o && !tgt_req_ready_i) |=>
      (tgt_req_valid_o && $stable(tgt_req_addr_o) && $stable(tgt_req_op_o) &&
       $stable(tgt_req_wdata_o) && $stable(tgt_req_id_o)));

endmodule

`default_nettype wire

//--- logic/xbar_top.sv
// ======================================
// Address-routed crossbar top level
// Opcode and write data go straight to
// the arbiters, read data to the demuxes
// ======================================
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defines.svh"

module xbar_top (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  input  logic [`XBAR_NUM_INIT-1:0]                         init_req_valid_i,
  output logic [`XBAR_NUM_INIT-1:0]                         init_req_ready_o,
  input  xbar_map_pkg::addr_t [`XBAR_NUM_INIT-1:0]          init_req_addr_i,
  input  xbar_bus_pkg::xbar_op_e [`XBAR_NUM_INIT-1:0]       init_req_op_i,
  input  xbar_map_pkg::data_t [`XBAR_NUM_INIT-1:0]          init_req_wdata_i,
  output logic [`XBAR_NUM_INIT-1:0]                         init_rsp_valid_o,
  input  logic [`XBAR_NUM_INIT-1:0]                         init_rsp_ready_i,
  output xbar_map_pkg::data_t [`XBAR_NUM_INIT-1:0]          init_rsp_rdata_o,
  output xbar_bus_pkg::xbar_status_e [`XBAR_NUM_INIT-1:0]   init_rsp_status_o,
  output logic [`XBAR_NUM_TGT-1:0]                          tgt_req_valid_o,
  input  logic [`XBAR_NUM_TGT-1:0]                          tgt_req_ready_i,
  output xbar_map_pkg::addr_t [`XBAR_NUM_TGT-1:0]           tgt_req_addr_o,
  output xbar_bus_pkg::xbar_op_e [`XBAR_NUM_TGT-1:0]        tgt_req_op_o,
  output xbar_map_pkg::data_t [`XBAR_NUM_TGT-1:0]           tgt_req_wdata_o,
  output xbar_map_pkg::id_t [`XBAR_NUM_TGT-1:0]             tgt_req_id_o,
  input  logic [`XBAR_NUM_TGT-1:0]                          tgt_rsp_valid_i,
  output logic [`XBAR_NUM_TGT-1:0]                          tgt_rsp_ready_o,
  input  xbar_map_pkg::id_t [`XBAR_NUM_TGT-1:0]             tgt_rsp_id_i,
  input  xbar_map_pkg::data_t [`XBAR_NUM_TGT-1:0]           tgt_rsp_rdata_i
);

  // Demux side, indexed initiator then target
  logic [`XBAR_NUM_INIT-1:0][`XBAR_NUM_TGT-1:0] dmx_req_valid;
  logic [`XBAR_NUM_INIT-1:0][`XBAR_NUM_TGT-1:0] dmx_req_ready;
  logic [`XBAR_NUM_INIT-1:0][`XBAR_NUM_TGT-1:0] dmx_rsp_valid;
  logic [`XBAR_NUM_INIT-1:0][`XBAR_NUM_TGT-1:0] dmx_rsp_ready;

  // Arbiter side, indexed target then initiator
  logic [`XBAR_NUM_TGT-1:0][`XBAR_NUM_INIT-1:0] arb_req_valid;
  logic [`XBAR_NUM_TGT-1:0][`XBAR_NUM_INIT-1:0] arb_req_ready;
  logic [`XBAR_NUM_TGT-1:0][`XBAR_NUM_INIT-1:0] arb_rsp_valid;
  logic [`XBAR_NUM_TGT-1:0][`XBAR_NUM_INIT-1:0] arb_rsp_ready;

  for (genvar i = 0; i < `XBAR_NUM_INIT; i++) begin : gen_init
    for (genvar t = 0; t < `XBAR_NUM_TGT; t++) begin : gen_cross
      assign arb_req_valid[t][i] = dmx_req_valid[i][t];
      assign dmx_req_ready[i][t] = arb_req_ready[t][i];
      assign dmx_rsp_valid[i][t] = arb_rsp_valid[t][i];
      assign arb_rsp_ready[t][i] = dmx_rsp_ready[i][t];
    end

    xbar_init_demux i_init_demux (
      .clk_i           ( clk_i                ),
      .arst_n_i        ( arst_n_i             ),
      .req_valid_i     ( init_req_valid_i[i]  ),
      .req_ready_o     ( init_req_ready_o[i]  ),
      .req_addr_i      ( init_req_addr_i[i]   ),
      .rsp_valid_o     ( init_rsp_valid_o[i]  ),
      .rsp_ready_i     ( init_rsp_ready_i[i]  ),
      .rsp_rdata_o     ( init_rsp_rdata_o[i]  ),
      .rsp_status_o    ( init_rsp_status_o[i] ),
      .tgt_req_valid_o ( dmx_req_valid[i]     ),
      .tgt_req_ready_i ( dmx_req_ready[i]     ),
      .tgt_rsp_valid_i ( dmx_rsp_valid[i]     ),
      .tgt_rsp_ready_o ( dmx_rsp_ready[i]     ),
      .tgt_rsp_rdata_i ( tgt_rsp_rdata_i      )
    );
  end

  for (genvar t = 0; t < `XBAR_NUM_TGT; t++) begin : gen_tgt
    xbar_tgt_arbiter i_tgt_arbiter (
      .clk_i           ( clk_i              ),
      .arst_n_i        ( arst_n_i           ),
      .req_valid_i     ( arb_req_valid[t]   ),
      .req_ready_o     ( arb_req_ready[t]   ),
      .req_addr_i      ( init_req_addr_i    ),
      .req_op_i        ( init_req_op_i      ),
      .req_wdata_i     ( init_req_wdata_i   ),
      .rsp_valid_o     ( arb_rsp_valid[t]   ),
      .rsp_ready_i     ( arb_rsp_ready[t]   ),
      .tgt_req_valid_o ( tgt_req_valid_o[t] ),
      .tgt_req_ready_i ( tgt_req_ready_i[t] ),
      .tgt_req_addr_o  ( tgt_req_addr_o[t]  ),
      .tgt_req_op_o    ( tgt_req_op_o[t]    ),
      .tgt_req_wdata_o ( tgt_req_wdata_o[t] ),
      .tgt_req_id_o    ( tgt_req_id_o[t]    ),
      .tgt_rsp_valid_i ( tgt_rsp_valid_i[t] ),
      .tgt_rsp_ready_o ( tgt_rsp_ready_o[t] ),
      .tgt_rsp_id_i    ( tgt_rsp_id_i[t]    )
    );
  end

endmodule

`default_nettype wire

//--- bench/xbar_tb_target.sv
// ========================================
// Behavioral memory target for the bench
// Answers in request order, zero data on
// writes; unwritten words read as zero
// ========================================
`timescale 1ns/10ps
`default_nettype none

module xbar_tb_target (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  xbar_map_pkg::addr_t    req_addr_i,
  input  xbar_bus_pkg::xbar_op_e req_op_i,
  input  xbar_map_pkg::data_t    req_wdata_i,
  input  xbar_map_pkg::id_t      req_id_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output xbar_map_pkg::id_t      rsp_id_o,
  output xbar_map_pkg::data_t    rsp_rdata_o
);

  // Word storage keyed by word address
  xbar_map_pkg::data_t mem [int unsigned];
  // Pending responses in arrival order
  xbar_map_pkg::id_t   id_q [$];
  xbar_map_pkg::data_t data_q [$];

  initial begin
    logic hold;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_id_o    = '0;
    rsp_rdata_o = '0;
    forever begin
      @(posedge clk_i);
      hold = 1'b0;
      if (!arst_n_i) begin
        id_q.delete();
        data_q.delete();
      end else begin
        if (req_valid_i && req_ready_o) begin
          id_q.push_back(req_id_i);
          if (req_op_i == xbar_bus_pkg::OP_WRITE) begin
            mem[int'(req_addr_i) >> 2] = req_wdata_i;
            data_q.push_back('0);
          end else if (mem.exists(int'(req_addr_i) >> 2)) begin
            data_q.push_back(mem[int'(req_addr_i) >> 2]);
          end else begin
            data_q.push_back('0);
          end
        end
        if (rsp_valid_o && rsp_ready_i) begin
          void'(id_q.pop_front());
          void'(data_q.pop_front());
        end
        // Offered response stays until taken
        hold = rsp_valid_o && !rsp_ready_i;
      end
      #1;
      if (!arst_n_i) begin
        req_ready_o = 1'b0;
        rsp_valid_o = 1'b0;
      end else begin
        // Random back-pressure on requests
        req_ready_o = ($urandom % 4) != 0;
        if (!hold) begin
          // Random response delay
          rsp_valid_o = (id_q.size() != 0) && (($urandom % 3) == 0);
          if (rsp_valid_o) begin
            rsp_id_o    = id_q[0];
            rsp_rdata_o = data_q[0];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/xbar_tb.sv
// ========================================
// Crossbar testbench, two initiators
// Initiator i uses words with addr bit 2
// equal to i, so expectations never mix
// ========================================
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defines.svh"

module xbar_tb;

  localparam int NI             = `XBAR_NUM_INIT;
  localparam int NT             = `XBAR_NUM_TGT;
  localparam int TRANS_PER_INIT = 150;
  localparam int TIMEOUT_CYCLES = 300 * 40 + 200;

  logic                                         clk;
  logic                                         arst_n;
  logic [NI-1:0]                                init_req_valid;
  logic [NI-1:0]                                init_req_ready;
  xbar_map_pkg::addr_t [NI-1:0]                 init_req_addr;
  xbar_bus_pkg::xbar_op_e [NI-1:0]              init_req_op;
  xbar_map_pkg::data_t [NI-1:0]                 init_req_wdata;
  logic [NI-1:0]                                init_rsp_valid;
  logic [NI-1:0]                                init_rsp_ready;
  xbar_map_pkg::data_t [NI-1:0]                 init_rsp_rdata;
  xbar_bus_pkg::xbar_status_e [NI-1:0]          init_rsp_status;
  logic [NT-1:0]                                tgt_req_valid;
  logic [NT-1:0]                                tgt_req_ready;
  xbar_map_pkg::addr_t [NT-1:0]                 tgt_req_addr;
  xbar_bus_pkg::xbar_op_e [NT-1:0]              tgt_req_op;
  xbar_map_pkg::data_t [NT-1:0]                 tgt_req_wdata;
  xbar_map_pkg::id_t [NT-1:0]                   tgt_req_id;
  logic [NT-1:0]                                tgt_rsp_valid;
  logic [NT-1:0]                                tgt_rsp_ready;
  xbar_map_pkg::id_t [NT-1:0]                   tgt_rsp_id;
  xbar_map_pkg::data_t [NT-1:0]                 tgt_rsp_rdata;

  // Shadow of every written word
  xbar_map_pkg::data_t        shadow [int unsigned];
  // Expected responses per initiator, in issue order
  xbar_map_pkg::data_t        exp_data_q [NI][$];
  xbar_bus_pkg::xbar_status_e exp_status_q [NI][$];
  int                         errors;
  int                         checks;
  int unsigned                cycle_cnt;

  xbar_top UUT (
    .clk_i             ( clk             ),
    .arst_n_i          ( arst_n          ),
    .init_req_valid_i  ( init_req_valid  ),
    .init_req_ready_o  ( init_req_ready  ),
    .init_req_addr_i   ( init_req_addr   ),
    .init_req_op_i     ( init_req_op     ),
    .init_req_wdata_i  ( init_req_wdata  ),
    .init_rsp_valid_o  ( init_rsp_valid  ),
    .init_rsp_ready_i  ( init_rsp_ready  ),
    .init_rsp_rdata_o  ( init_rsp_rdata  ),
    .init_rsp_status_o ( init_rsp_status ),
    .tgt_req_valid_o   ( tgt_req_valid   ),
    .tgt_req_ready_i   ( tgt_req_ready   ),
    .tgt_req_addr_o    ( tgt_req_addr    ),
    .tgt_req_op_o      ( tgt_req_op      ),
    .tgt_req_wdata_o   ( tgt_req_wdata   ),
    .tgt_req_id_o      ( tgt_req_id      ),
    .tgt_rsp_valid_i   ( tgt_rsp_valid   ),
    .tgt_rsp_ready_o   ( tgt_rsp_ready   ),
    .tgt_rsp_id_i      ( tgt_rsp_id      ),
    .tgt_rsp_rdata_i   ( tgt_rsp_rdata   )
  );

  for (genvar t = 0; t < NT; t++) begin : gen_tgt
    xbar_tb_target i_target (
      .clk_i       ( clk              ),
      .arst_n_i    ( arst_n           ),
      .req_valid_i ( tgt_req_valid[t] ),
      .req_ready_o ( tgt_req_ready[t] ),
      .req_addr_i  ( tgt_req_addr[t]  ),
      .req_op_i    ( tgt_req_op[t]    ),
      .req_wdata_i ( tgt_req_wdata[t] ),
      .req_id_i    ( tgt_req_id[t]    ),
      .rsp_valid_o ( tgt_rsp_valid[t] ),
      .rsp_ready_i ( tgt_rsp_ready[t] ),
      .rsp_id_o    ( tgt_rsp_id[t]    ),
      .rsp_rdata_o ( tgt_rsp_rdata[t] )
    );
  end

  always #20 clk = ~clk;

  // Expected response from the address map and shadow memory
  function automatic void predict(input int idx, input xbar_map_pkg::addr_t addr,
                                  input xbar_bus_pkg::xbar_op_e op,
                                  input xbar_map_pkg::data_t wdata);
    if (int'(addr) >= NT * `XBAR_TGT_SIZE) begin
      exp_data_q[idx].push_back('0);
      exp_status_q[idx].push_back(xbar_bus_pkg::RSP_DECERR);
    end else begin
      if (op == xbar_bus_pkg::OP_WRITE) begin
        shadow[int'(addr) >> 2] = wdata;
        exp_data_q[idx].push_back('0);
      end else if (shadow.exists(int'(addr) >> 2)) begin
        exp_data_q[idx].push_back(shadow[int'(addr) >> 2]);
      end else begin
        exp_data_q[idx].push_back('0);
      end
      exp_status_q[idx].push_back(xbar_bus_pkg::RSP_OKAY);
    end
  endfunction

  // About one in eight unmapped, mapped words drawn from a small set
  function automatic xbar_map_pkg::addr_t pick_addr(input int idx);
    int unsigned r;
    r = $urandom;
    if ((r % 8) == 0) begin
      return xbar_map_pkg::addr_t'(16'h2000 + ((r >> 4) % 16'h0C00) * 8 + idx * 4);
    end
    return xbar_map_pkg::addr_t'(((r >> 4) % NT) * `XBAR_TGT_SIZE +
                                 ((r >> 6) % 8) * 8 + idx * 4);
  endfunction

  task automatic run_initiator(input int idx);
    xbar_map_pkg::addr_t    addr;
    xbar_bus_pkg::xbar_op_e op;
    xbar_map_pkg::data_t    wdata;
    for (int n = 0; n < TRANS_PER_INIT; n++) begin
      addr  = pick_addr(idx);
      op    = (($urandom % 2) != 0) ? xbar_bus_pkg::OP_WRITE : xbar_bus_pkg::OP_READ;
      wdata = $urandom;
      // Directed start: write then read on each target, then one unmapped
      if (n < 2 * NT) begin
        addr = xbar_map_pkg::addr_t'((n / 2) * `XBAR_TGT_SIZE + idx * 4);
        op   = ((n % 2) == 0) ? xbar_bus_pkg::OP_WRITE : xbar_bus_pkg::OP_READ;
      end else if (n == 2 * NT) begin
        addr = xbar_map_pkg::addr_t'(16'hF000 + idx * 4);
      end
      predict(idx, addr, op, wdata);
      init_req_valid[idx] = 1'b1;
      init_req_addr[idx]  = addr;
      init_req_op[idx]    = op;
      init_req_wdata[idx] = wdata;
      do begin
        @(posedge clk);
      end while (!init_req_ready[idx]);
      #1;
      init_req_valid[idx] = 1'b0;
      // Occasional idle cycle between requests
      if (($urandom % 4) == 0) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic check_idle();
    assert (init_rsp_valid == '0) else begin
      $display("FAIL %0t init_rsp_valid_o got %b expected 0", $time, init_rsp_valid);
      errors++;
    end
    assert (tgt_req_valid == '0) else begin
      $display("FAIL %0t tgt_req_valid_o got %b expected 0", $time, tgt_req_valid);
      errors++;
    end
  endtask

  // Compare every response handshake against the queue head
  always @(posedge clk) begin : compare_rsp
    xbar_map_pkg::data_t        exp_data;
    xbar_bus_pkg::xbar_status_e exp_status;
    for (int i = 0; i < NI; i++) begin
      if (arst_n && init_rsp_valid[i] && init_rsp_ready[i]) begin
        assert (exp_data_q[i].size() != 0) else begin
          $display("Initiator %0d got a response at %0t with nothing outstanding", i, $time);
          errors++;
        end
        if (exp_data_q[i].size() != 0) begin
          exp_data   = exp_data_q[i].pop_front();
          exp_status = exp_status_q[i].pop_front();
          checks++;
          assert (init_rsp_rdata[i] === exp_data) else begin
            $display("FAIL %0t init_rsp_rdata_o[%0d] got %h expected %h",
                     $time, i, init_rsp_rdata[i], exp_data);
            errors++;
          end
          assert (init_rsp_status[i] === exp_status) else begin
            $display("FAIL %0t init_rsp_status_o[%0d] got %s expected %s",
                     $time, i, init_rsp_status[i].name(), exp_status.name());
            errors++;
          end
        end
      end
    end
  end

  // Each target only sees requests from its own address window
  always @(posedge clk) begin : check_route
    for (int t = 0; t < NT; t++) begin
      if (arst_n && tgt_req_valid[t] && tgt_req_ready[t]) begin
        assert (int'(tgt_req_addr[t]) / `XBAR_TGT_SIZE == t) else begin
          $display("FAIL %0t tgt_req_addr_o[%0d] got %h expected %h to %h", $time, t,
                   tgt_req_addr[t], t * `XBAR_TGT_SIZE, (t + 1) * `XBAR_TGT_SIZE - 1);
          errors++;
        end
      end
    end
  end

  // Random response back-pressure from the initiators
  initial begin
    init_rsp_ready = '0;
    forever begin
      @(posedge clk);
      #1;
      for (int i = 0; i < NI; i++) begin
        init_rsp_ready[i] = ($urandom % 4) != 0;
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run hung after %0d cycles", cycle_cnt);
    $display("errors: %0d, responses checked: %0d", errors + 1, checks);
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h3401));
    errors         = 0;
    checks         = 0;
    clk            = 1'b0;
    arst_n         = 1'b0;
    init_req_valid = '0;
    init_req_addr  = '0;
    init_req_op    = {NI{xbar_bus_pkg::OP_READ}};
    init_req_wdata = '0;
    repeat (5) begin
      @(posedge clk);
      check_idle();
    end
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    check_idle();
    #1;
    fork
      run_initiator(0);
      run_initiator(1);
    join
    // Drain outstanding responses, then watch for strays
    while (exp_data_q[0].size() != 0 || exp_data_q[1].size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);
    $display("errors: %0d, responses checked: %0d", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
logic/xbar_map_pkg.sv
logic/xbar_bus_pkg.sv
logic/xbar_trans_counter.sv
logic/xbar_decerr_target.sv
logic/xbar_init_demux.sv
logic/xbar_tgt_arbiter.sv
logic/xbar_top.sv
bench/xbar_tb_target.sv
bench/xbar_tb.sv
